//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_top
FILELIST = tb.f
LOG      = sim.log

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- hw/axi_lite_master.sv
`timescale 1ns/10ps

module axi_lite_master import io_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  io_req_t     req,
  output logic        stall,
  output logic [31:0] rdata,
  output logic        rdata_valid,
  output axi_m2s_t    axi_out,
  input  axi_s2m_t    axi_in
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_WRITE
  } state_e;

  state_e      state_q;
  logic        ar_pend, r_pend;            // Channel still waiting for its handshake
  logic        aw_pend, w_pend, b_pend;
  logic        b_err_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic        ar_fire, r_fire, aw_fire, w_fire, b_fire;
  logic        rd_done, wr_done, b_err;

  assign ar_fire = ar_pend & axi_in.arready;
  assign r_fire  = r_pend & axi_in.r.valid;
  assign aw_fire = aw_pend & axi_in.awready;
  assign w_fire  = w_pend & axi_in.wready;
  assign b_fire  = b_pend & axi_in.b.valid;

  assign rd_done = (state_q == S_READ) && (!ar_pend || ar_fire) && (!r_pend || r_fire);
  assign wr_done = (state_q == S_WRITE) && (!aw_pend || aw_fire) && (!w_pend || w_fire)
                   && (!b_pend || b_fire);
  assign b_err   = b_fire ? (axi_in.b.resp != AXI_RESP_OKAY) : b_err_q;

  // A failed write keeps the requester stalled and restarts from idle
  assign stall = ((state_q == S_IDLE) && (req.op != IO_IDLE))
              || ((state_q == S_READ) && !rd_done)
              || ((state_q == S_WRITE) && (!wr_done || b_err));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      ar_pend <= 1'b0;
      r_pend  <= 1'b0;
      aw_pend <= 1'b0;
      w_pend  <= 1'b0;
      b_pend  <= 1'b0;
      b_err_q <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          b_err_q <= 1'b0;
          if (req.op == IO_READ) begin
            ar_pend <= 1'b1;
            r_pend  <= 1'b1;
            state_q <= S_READ;
          end else if (req.op == IO_WRITE) begin
            aw_pend <= 1'b1;
            w_pend  <= 1'b1;
            b_pend  <= 1'b1;
            state_q <= S_WRITE;
          end
        end
        S_READ: begin
          if (ar_fire) ar_pend <= 1'b0;
          if (r_fire)  r_pend  <= 1'b0;
          if (rd_done) state_q <= S_IDLE;
        end
        S_WRITE: begin
          if (aw_fire) aw_pend <= 1'b0;
          if (w_fire)  w_pend  <= 1'b0;
          if (b_fire) begin
            b_pend  <= 1'b0;
            b_err_q <= (axi_in.b.resp != AXI_RESP_OKAY);
          end
          if (wr_done) state_q <= S_IDLE;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Payload captured at start, held until the transfer ends
  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && req.op != IO_IDLE) begin
      addr_q  <= req.addr;
      wdata_q <= req.wdata;
    end
  end

  always_comb begin
    axi_out.ar.addr  = addr_q;
    axi_out.ar.valid = ar_pend;
    axi_out.aw.addr  = addr_q;
    axi_out.aw.valid = aw_pend;
    axi_out.w.data   = wdata_q;
    axi_out.w.strb   = 4'hF;      // Full word only
    axi_out.w.valid  = w_pend;
    axi_out.rready   = r_pend;
    axi_out.bready   = b_pend;
  end

  assign rdata       = axi_in.r.data;
  assign rdata_valid = r_fire;

  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    axi_out.ar.valid && !axi_in.arready |=> axi_out.ar.valid && $stable(axi_out.ar.addr));

  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    axi_out.aw.valid && !axi_in.awready |=> axi_out.aw.valid && $stable(axi_out.aw.addr));

endmodule

//--- hw/io_bridge.sv
`timescale 1ns/10ps

module io_bridge import io_pkg::*, sysctrl_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  io_req_t          req,
  output logic             stall,
  output logic [31:0]      rdata,
  output logic             rdata_valid,
  input  logic [IRQ_W-1:0] intr,
  output logic             mtip,
  output logic             meip,
  output axi_m2s_t         axi_out,
  input  axi_s2m_t         axi_in
);

  logic        is_sys;
  io_req_t     sys_req;
  io_req_t     axi_req;
  logic [31:0] sys_rdata;
  logic [31:0] axi_rdata;
  logic        axi_rdata_valid;
  logic        sys_rd;
  logic [31:0] rdata_q;
  logic        rdata_valid_q;

  assign is_sys = (req.addr[31:12] == SYS_BASE);

  // Exactly one target sees a live op
  always_comb begin
    sys_req = req;
    axi_req = req;
    if (is_sys) axi_req.op = IO_IDLE;
    else        sys_req.op = IO_IDLE;
  end

  assign sys_rd = (sys_req.op == IO_READ);  // Accepted in the cycle it appears

  sysctrl u_sys (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (sys_req),
    .rdata (sys_rdata),
    .intr  (intr),
    .mtip  (mtip),
    .meip  (meip)
  );

  axi_lite_master u_axi (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (axi_req),
    .stall       (stall),         // System controller never stalls
    .rdata       (axi_rdata),
    .rdata_valid (axi_rdata_valid),
    .axi_out     (axi_out),
    .axi_in      (axi_in)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) rdata_valid_q <= 1'b0;
    else        rdata_valid_q <= sys_rd | axi_rdata_valid;
  end

  always_ff @(posedge clk) begin
    if (sys_rd || axi_rdata_valid) begin
      rdata_q <= sys_rd ? sys_rdata : axi_rdata;  // Held until the next read
    end
  end

  assign rdata       = rdata_q;
  assign rdata_valid = rdata_valid_q;

  no_idle_stall: assert property (@(posedge clk) disable iff (!rst_n)
    req.op == IO_IDLE |-> !stall);

endmodule

//--- hw/io_pkg.sv
package io_pkg;

  typedef enum logic [1:0] {
    IO_IDLE  = 2'b00,
    IO_READ  = 2'b01,
    IO_WRITE = 2'b10
  } io_op_t;

  typedef struct packed {
    io_op_t      op;
    logic [31:0] addr;
    logic [31:0] wdata;
  } io_req_t;

  typedef struct packed {
    logic [31:0] addr;
    logic        valid;
  } axi_ar_t;

  typedef struct packed {
    logic [31:0] addr;
    logic        valid;
  } axi_aw_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
    logic        valid;
  } axi_w_t;

  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
    logic        valid;
  } axi_r_t;

  typedef struct packed {
    logic [1:0] resp;
    logic       valid;
  } axi_b_t;

  // Master to slave
  typedef struct packed {
    axi_ar_t ar;
    axi_aw_t aw;
    axi_w_t  w;
    logic    rready;
    logic    bready;
  } axi_m2s_t;

  // Slave to master
  typedef struct packed {
    logic   arready;
    logic   awready;
    logic   wready;
    axi_r_t r;
    axi_b_t b;
  } axi_s2m_t;

  localparam logic [19:0] SYS_BASE      = 20'hF0000;  // addr[31:12] of system controller
  localparam logic [1:0]  AXI_RESP_OKAY = 2'b00;

endpackage

//--- hw/irq_ctrl.sv
`timescale 1ns/10ps

module irq_ctrl import sysctrl_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [IRQ_W-1:0] intr,
  input  logic             enable_we,
  input  logic             clear_we,
  input  logic [31:0]      wdata,
  output logic [IRQ_W-1:0] detected,
  output logic [IRQ_W-1:0] enable,
  output logic             meip
);

  logic [SYNC_STAGES-1:0][IRQ_W-1:0] sync_q;
  logic [IRQ_W-1:0] synced;
  logic [IRQ_W-1:0] prev_q;    // Synced value one clock earlier
  logic [IRQ_W-1:0] rise;
  logic [IRQ_W-1:0] clear_mask;
  logic [IRQ_W-1:0] pending_q;
  logic [IRQ_W-1:0] enable_q;

  assign synced     = sync_q[SYNC_STAGES-1];
  assign rise       = synced & ~prev_q;
  assign clear_mask = clear_we ? wdata[IRQ_W-1:0] : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '0;
      prev_q <= '0;
    end else begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], intr};  // Shift toward the last stage
      prev_q <= synced;
    end
  end

  // A new edge wins over a clear in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      pending_q <= (pending_q & ~clear_mask) | rise;
      if (enable_we) begin
        enable_q <= wdata[IRQ_W-1:0];
      end
    end
  end

  assign detected = pending_q & enable_q;
  assign enable   = enable_q;
  assign meip     = |detected;  // Level, stays up until cleared

endmodule

//--- hw/mtimer.sv
`timescale 1ns/10ps

module mtimer import sysctrl_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cmp_l_we,
  input  logic        cmp_h_we,
  input  logic [31:0] wdata,
  output logic [63:0] mtime,
  output logic [63:0] mtimecmp,
  output logic        mtip
);

  logic [DIV_W-1:0] div_q;
  logic             tick;
  logic [63:0]      mtime_q;
  logic [63:0]      cmp_q;

  assign tick = (div_q == DIV_W'(MTIME_DIV - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_q   <= '0;
      mtime_q <= '0;
    end else begin
      div_q <= tick ? '0 : div_q + 1'b1;
      if (tick) begin
        mtime_q <= mtime_q + 64'd1;
      end
    end
  end

  // Compare register is written one half at a time
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmp_q <= '0;
    end else begin
      if (cmp_l_we) cmp_q[31:0]  <= wdata;
      if (cmp_h_we) cmp_q[63:32] <= wdata;
    end
  end

  assign mtime    = mtime_q;
  assign mtimecmp = cmp_q;
  assign mtip     = (mtime_q >= cmp_q);  // High out of reset, both are zero

endmodule

//--- hw/sysctrl.sv
`timescale 1ns/10ps

module sysctrl import io_pkg::*, sysctrl_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  io_req_t          req,
  output logic [31:0]      rdata,
  input  logic [IRQ_W-1:0] intr,
  output logic             mtip,
  output logic             meip
);

  reg_addr_t        offset;
  logic             is_wr;
  logic [IRQ_W-1:0] detected;
  logic [IRQ_W-1:0] enable;
  logic [63:0]      mtime;
  logic [63:0]      mtimecmp;

  assign offset = reg_addr_t'(req.addr[4:0]);
  assign is_wr  = (req.op == IO_WRITE);

  // Writes to the mtime offsets fall through, mtime is read only
  irq_ctrl u_irq (
    .clk       (clk),
    .rst_n     (rst_n),
    .intr      (intr),
    .enable_we (is_wr && offset == REG_ENABLE),
    .clear_we  (is_wr && offset == REG_IRQ),    // Write 1 to clear
    .wdata     (req.wdata),
    .detected  (detected),
    .enable    (enable),
    .meip      (meip)
  );

  mtimer u_timer (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmp_l_we (is_wr && offset == REG_CMP_L),
    .cmp_h_we (is_wr && offset == REG_CMP_H),
    .wdata    (req.wdata),
    .mtime    (mtime),
    .mtimecmp (mtimecmp),
    .mtip     (mtip)
  );

  always_comb begin
    rdata = '0;
    if (req.op == IO_READ) begin
      case (offset)
        REG_IRQ:     rdata = 32'(detected);
        REG_ENABLE:  rdata = 32'(enable);
        REG_MTIME_L: rdata = mtime[31:0];
        REG_MTIME_H: rdata = mtime[63:32];
        REG_CMP_L:   rdata = mtimecmp[31:0];
        REG_CMP_H:   rdata = mtimecmp[63:32];
        default:     rdata = '0;
      endcase
    end
  end

endmodule

//--- hw/sysctrl_pkg.sv
package sysctrl_pkg;

  localparam int IRQ_W       = 7;  // External interrupt lines
  localparam int SYNC_STAGES = 3;

  typedef logic [4:0] reg_addr_t;

  // Register offsets within the system controller window
  localparam reg_addr_t REG_IRQ     = 5'h00;
  localparam reg_addr_t REG_ENABLE  = 5'h08;
  localparam reg_addr_t REG_MTIME_L = 5'h10;
  localparam reg_addr_t REG_MTIME_H = 5'h14;
  localparam reg_addr_t REG_CMP_L   = 5'h18;
  localparam reg_addr_t REG_CMP_H   = 5'h1C;

  localparam int MTIME_DIV = 16;                  // Clocks per mtime tick
  localparam int DIV_W     = $clog2(MTIME_DIV);

endpackage

//--- tb.f
hw/io_pkg.sv
hw/sysctrl_pkg.sv
hw/irq_ctrl.sv
hw/mtimer.sv
hw/sysctrl.sv
hw/axi_lite_master.sv
hw/io_bridge.sv
test/tb_axi_mem.sv
test/tb_top.sv

//--- test/tb_axi_mem.sv
`timescale 1ns/10ps

module tb_axi_mem import io_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  axi_m2s_t    axi_in,
  output axi_s2m_t    axi_out,
  output logic [31:0] writes_at_40
);

  logic [31:0] mem [0:255];
  integer      seed = 32'h9112;
  int          ar_dly;
  int          r_dly;
  int          aw_dly;
  int          w_dly;
  int          b_dly;
  logic        r_busy;
  logic        aw_got;
  logic        w_got;
  logic        err_sent;    // SLVERR already given once
  logic [31:0] r_addr;
  logic [31:0] w_addr;
  logic [31:0] w_data;

  function automatic int next_dly();
    return int'($unsigned($random(seed)) % 4);
  endfunction

  // Outputs change on the falling edge, so a raised ready or valid
  // always meets its partner at the next rising edge
  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      axi_out      = '0;
      writes_at_40 = '0;
      r_busy       = 1'b0;
      aw_got       = 1'b0;
      w_got        = 1'b0;
      err_sent     = 1'b0;
      ar_dly       = 0;
      r_dly        = 0;
      aw_dly       = 0;
      w_dly        = 0;
      b_dly        = 0;
      for (int i = 0; i < 256; i++) begin
        mem[i] = 32'hC0DE_0000 | (32'(i) << 2);  // Fill tied to the byte address
      end
    end else begin
      if (axi_out.r.valid) begin
        axi_out.r.valid = 1'b0;  // Taken at the last rising edge
        r_busy          = 1'b0;
      end else if (r_busy) begin
        if (r_dly == 0) begin
          axi_out.r.valid = 1'b1;
          axi_out.r.data  = mem[r_addr[9:2]];
          axi_out.r.resp  = AXI_RESP_OKAY;
        end else r_dly--;
      end

      if (axi_out.arready) begin
        axi_out.arready = 1'b0;
        r_busy          = 1'b1;
        r_dly           = next_dly();
      end else if (axi_in.ar.valid && !r_busy) begin
        if (ar_dly == 0) begin
          axi_out.arready = 1'b1;
          r_addr          = axi_in.ar.addr;
          ar_dly          = next_dly();
        end else ar_dly--;
      end

      if (axi_out.awready) begin
        axi_out.awready = 1'b0;
        aw_got          = 1'b1;
      end else if (axi_in.aw.valid && !aw_got && !axi_out.b.valid) begin
        if (aw_dly == 0) begin
          axi_out.awready = 1'b1;
          w_addr          = axi_in.aw.addr;
          aw_dly          = next_dly();
        end else aw_dly--;
      end

      if (axi_out.wready) begin
        axi_out.wready = 1'b0;
        w_got          = 1'b1;
      end else if (axi_in.w.valid && !w_got && !axi_out.b.valid) begin
        if (w_dly == 0) begin
          axi_out.wready = 1'b1;
          w_data         = axi_in.w.data;
          w_dly          = next_dly();
        end else w_dly--;
      end

      // Response once both address and data are in
      if (axi_out.b.valid) begin
        axi_out.b.valid = 1'b0;
      end else if (aw_got && w_got) begin
        if (b_dly == 0) begin
          aw_got          = 1'b0;
          w_got           = 1'b0;
          b_dly           = next_dly();
          axi_out.b.valid = 1'b1;
          if (w_addr == 32'h0000_0040) writes_at_40++;
          if (w_addr == 32'h0000_0040 && !err_sent) begin
            err_sent       = 1'b1;
            axi_out.b.resp = 2'b10;  // SLVERR, memory untouched
          end else begin
            axi_out.b.resp     = AXI_RESP_OKAY;
            mem[w_addr[9:2]]   = w_data;
          end
        end else b_dly--;
      end
    end
  end

endmodule

//--- test/tb_top.sv
`timescale 1ns/10ps

module tb_top import io_pkg::*, sysctrl_pkg::*; ();

  localparam int N_TESTS     = 5;
  localparam int TEST_CYCLES = 2000;
  localparam int N_RAND      = 20;

  typedef struct packed {
    logic        chk;
    logic [31:0] addr;
    logic [31:0] val;
  } exp_t;

  logic             clk = 1'b0;
  logic             rst_n;
  io_req_t          req;
  logic             stall;
  logic [31:0]      rdata;
  logic             rdata_valid;
  logic [IRQ_W-1:0] intr;
  logic             mtip;
  logic             meip;
  axi_m2s_t         axi_m2s;
  axi_s2m_t         axi_s2m;
  logic [31:0]      writes_at_40;

  integer           seed = 32'h9112;
  int               errors = 0;
  int               checks = 0;
  int               tests_run = 0;
  int               test_err0 = 0;
  int               n;
  exp_t             exp_q[$];
  exp_t             exp_e;
  logic [31:0]      exp_mem [0:255];
  logic [31:0]      rand_addr [0:N_RAND-1];
  logic [IRQ_W-1:0] model_enable;
  logic [IRQ_W-1:0] model_pending;
  logic [63:0]      model_cmp;
  logic [31:0]      rd;

  always #5 clk = ~clk;

  io_bridge dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .stall       (stall),
    .rdata       (rdata),
    .rdata_valid (rdata_valid),
    .intr        (intr),
    .mtip        (mtip),
    .meip        (meip),
    .axi_out     (axi_m2s),
    .axi_in      (axi_s2m)
  );

  tb_axi_mem slave0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .axi_in       (axi_m2s),
    .axi_out      (axi_s2m),
    .writes_at_40 (writes_at_40)
  );

  function automatic logic [31:0] sys_addr(input reg_addr_t off);
    return {SYS_BASE, 7'd0, off};
  endfunction

  // Expected register value from the tracked model, mtime is not modeled
  function automatic logic [31:0] ref_read(input reg_addr_t off);
    case (off)
      REG_IRQ:    return 32'(model_pending & model_enable);
      REG_ENABLE: return 32'(model_enable);
      REG_CMP_L:  return model_cmp[31:0];
      REG_CMP_H:  return model_cmp[63:32];
      default:    return 32'd0;
    endcase
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at %0d ns: %s, got %h, expected %h", $time, msg, actual, expected);
    end
  endtask

  // Holds the request until stall is low at a rising edge
  task automatic send_req(input io_op_t op, input logic [31:0] addr, input logic [31:0] wdata);
    @(negedge clk);
    req.op    = op;
    req.addr  = addr;
    req.wdata = wdata;
    #1;
    if (addr[31:12] == SYS_BASE) begin
      check({31'd0, stall}, 32'd0, "stall on a system controller request");
    end
    while (stall) begin
      @(negedge clk);
      #1;
    end
    @(posedge clk);  // Accepted here
    @(negedge clk);
    req.op = IO_IDLE;
  endtask

  task automatic read_word(input logic [31:0] addr, input logic chk,
                           input logic [31:0] expected, output logic [31:0] data);
    exp_t e;
    int   wait_n;
    e.chk  = chk;
    e.addr = addr;
    e.val  = expected;
    exp_q.push_back(e);
    send_req(IO_READ, addr, 32'd0);
    if (addr[31:12] == SYS_BASE) begin
      check({31'd0, rdata_valid}, 32'd1, "rdata_valid one cycle after a system read");
    end
    wait_n = 0;
    while (!rdata_valid && wait_n < 20) begin
      @(negedge clk);
      wait_n++;
    end
    if (!rdata_valid) begin
      errors++;
      $display("No read data came back for address %h", addr);
    end
    data = rdata;
  endtask

  task automatic pulse_irq(input int line);
    @(negedge clk);
    intr = IRQ_W'(1 << line);
    repeat (2) @(negedge clk);
    intr = '0;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("%s: done with %0d errors", name, errors - test_err0);
    test_err0 = errors;
  endtask

  // Read data against the queue of expected values
  initial begin
    forever begin
      @(negedge clk);
      if (rst_n === 1'b1 && rdata_valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Read data %h arrived with no read outstanding", rdata);
        end else begin
          exp_e = exp_q.pop_front();
          if (exp_e.chk) check(rdata, exp_e.val, $sformatf("read of %h", exp_e.addr));
        end
      end
    end
  end

  initial begin
    rst_n         = 1'b0;
    req           = '0;
    intr          = '0;
    model_enable  = '0;
    model_pending = '0;
    model_cmp     = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Both counters are zero out of reset
    check({31'd0, mtip}, 32'd1, "mtip out of reset");
    check({31'd0, meip}, 32'd0, "meip out of reset");

    // Timer goes first while mtime is still below 40
    send_req(IO_WRITE, sys_addr(REG_CMP_L), 32'd40);
    model_cmp[31:0] = 32'd40;
    check({31'd0, mtip}, 32'd0, "mtip after compare write");
    send_req(IO_WRITE, sys_addr(REG_CMP_H), 32'd0);
    model_cmp[63:32] = 32'd0;
    read_word(sys_addr(REG_CMP_L), 1'b1, ref_read(REG_CMP_L), rd);
    read_word(sys_addr(REG_CMP_H), 1'b1, ref_read(REG_CMP_H), rd);
    n = 0;
    while (!mtip && n < 40 * MTIME_DIV + 64) begin
      @(negedge clk);
      n++;
    end
    if (!mtip) begin
      errors++;
      $display("mtip did not rise within %0d cycles of the compare write", n);
    end
    read_word(sys_addr(REG_MTIME_L), 1'b0, 32'd0, rd);
    check({31'd0, rd >= 32'd40}, 32'd1, "mtime low word reached compare value");
    end_test("Machine timer");

    for (int i = 0; i < N_RAND; i++) begin
      rd = $random(seed);
      if (rd[7:0] == 8'h10) rd[7:0] = 8'h11;  // 0x40 kept for the error case
      rand_addr[i] = {22'd0, rd[7:0], 2'b00};
      rd = $random(seed);
      exp_mem[rand_addr[i][9:2]] = rd;
      send_req(IO_WRITE, rand_addr[i], rd);
    end
    for (int i = 0; i < N_RAND; i++) begin
      read_word(rand_addr[i], 1'b1, exp_mem[rand_addr[i][9:2]], rd);
    end
    end_test("Random AXI writes and reads");

    send_req(IO_WRITE, 32'h0000_0040, 32'hDEAD_BEEF);
    read_word(32'h0000_0040, 1'b1, 32'hDEAD_BEEF, rd);
    check(writes_at_40, 32'd2, "write attempts at 0x40");
    end_test("Write retry after SLVERR");

    rd = 32'hFFFF_FFD5;
    send_req(IO_WRITE, sys_addr(REG_ENABLE), rd);
    model_enable = rd[IRQ_W-1:0];
    read_word(sys_addr(REG_ENABLE), 1'b1, ref_read(REG_ENABLE), rd);
    read_word(sys_addr(5'h04), 1'b1, ref_read(5'h04), rd);
    read_word(sys_addr(5'h0C), 1'b1, ref_read(5'h0C), rd);
    end_test("Enable register and unknown offsets");

    send_req(IO_WRITE, sys_addr(REG_ENABLE), 32'h0000_0004);
    model_enable = IRQ_W'(4);
    pulse_irq(2);
    model_pending = model_pending | IRQ_W'(4);
    n = 0;
    while (!meip && n < 2 * SYNC_STAGES + 4) begin
      @(negedge clk);
      n++;
    end
    if (!meip) begin
      errors++;
      $display("meip did not rise after a pulse on enabled line 2");
    end
    read_word(sys_addr(REG_IRQ), 1'b1, ref_read(REG_IRQ), rd);
    send_req(IO_WRITE, sys_addr(REG_IRQ), 32'h0000_0004);  // Clear line 2
    model_pending = model_pending & ~IRQ_W'(4);
    check({31'd0, meip}, 32'd0, "meip after clear");
    pulse_irq(5);
    model_pending = model_pending | IRQ_W'(32);
    repeat (SYNC_STAGES + 2) @(negedge clk);
    check({31'd0, meip}, 32'd0, "meip with line 5 disabled");
    read_word(sys_addr(REG_IRQ), 1'b1, ref_read(REG_IRQ), rd);
    send_req(IO_WRITE, sys_addr(REG_ENABLE), 32'h0000_0024);
    model_enable = IRQ_W'(36);
    check({31'd0, meip}, 32'd1, "meip once line 5 is enabled");
    read_word(sys_addr(REG_IRQ), 1'b1, ref_read(REG_IRQ), rd);
    end_test("External interrupts");

    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(N_TESTS * TEST_CYCLES * 10);
    $display("Timeout: the run did not finish within %0d cycles", N_TESTS * TEST_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule
